// File: bench/ltsm_tb.sv
`timescale 1ns/100ps

module ltsm_tb;
    import ltsm_state_pkg::*;
    import sb_msg_pkg::*;

    localparam int RESET_DWELL     = 20;
    localparam int STATE_TIMEOUT   = 400;
    localparam int RETRY_CYCLES    = 30;
    // Covers a full dwell plus two resend intervals
    localparam int REQ_WAIT        = RESET_DWELL + 2 * RETRY_CYCLES + 20;
    localparam int WATCHDOG_CYCLES = 6 * (RESET_DWELL + 6 * STATE_TIMEOUT);

    // Request codes in training order, response bit and error entry code
    localparam sb_msg_t     EXP_REQ [4]    = '{8'h01, 8'h02, 8'h03, 8'h04};
    localparam sb_msg_t     EXP_RESP_BIT   = 8'h80;
    localparam sb_msg_t     EXP_ERR_MSG    = 8'h7F;
    localparam ltsm_state_t NEXT_STATE [4] = '{MBINIT, MBTRAIN, LINKINIT, ACTIVE};

    logic        clk_100MHz;
    logic        gen_reset;
    logic        tb_reset;
    logic        dut_reset;
    logic        enable;
    logic        start_lt;
    logic        send_next;
    logic        rx_valid;
    sb_msg_t     rx_msg;
    logic        tx_valid;
    sb_msg_t     tx_msg;
    ltsm_state_t ltsm_state;
    logic        link_active;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    logic [31:0] rng_state   = 32'd79;

    assign dut_reset = gen_reset | tb_reset;

    tb_clock_gen clock_gen_inst (
        .clk_100MHz(clk_100MHz),
        .reset     (gen_reset)
    );

    ltsm_top #(
        .RESET_DWELL  (RESET_DWELL),
        .STATE_TIMEOUT(STATE_TIMEOUT),
        .RETRY_CYCLES (RETRY_CYCLES)
    ) ltsm_top_inst (
        .clk_100MHz       (clk_100MHz),
        .reset            (dut_reset),
        .enable_i         (enable),
        .start_lt_i       (start_lt),
        .sb_tx_send_next_i(send_next),
        .sb_rx_valid_i    (rx_valid),
        .sb_rx_msg_i      (rx_msg),
        .sb_tx_valid_o    (tx_valid),
        .sb_tx_msg_o      (tx_msg),
        .ltsm_state_o     (ltsm_state),
        .ltsm_active_o    (link_active)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic step();
        @(posedge clk_100MHz);
        #1;
    endtask

    task automatic note_failure(input string name, input string text);
        error_count++;
        $display("%s: %s", name, text);
    endtask

    task automatic check_state(input string name, input ltsm_state_t exp, input ltsm_state_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected state %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_msg(input string name, input sb_msg_t exp, input sb_msg_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected message 0x%02h, actual 0x%02h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected bit %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic wait_state(input string name, input ltsm_state_t exp, input int limit);
        int waited;
        waited = 0;
        while (ltsm_state !== exp && waited < limit) begin
            step();
            waited++;
        end
        check_count++;
        if (ltsm_state !== exp) begin
            note_failure(name, $sformatf("state did not reach %s in %0d cycles", exp.name(), limit));
        end
    endtask

    // Partner side of the transmit port
    // Takes the message after a random stall
    task automatic accept_msg(input string name, input int stall_max, output sb_msg_t code);
        int      waited;
        int      stall;
        sb_msg_t held;
        waited = 0;
        code   = '0;
        while (tx_valid !== 1'b1 && waited < REQ_WAIT) begin
            step();
            waited++;
        end
        if (tx_valid !== 1'b1) begin
            note_failure(name, "no message appeared on the sideband transmit port");
        end else begin
            held  = tx_msg;
            stall = 0;
            if (stall_max > 0) begin
                rng_state = xorshift32(rng_state);
                stall     = int'(rng_state % (stall_max + 1));
            end
            repeat (stall) begin
                step();
                check_bit(name, 1'b1, tx_valid);
                check_msg(name, held, tx_msg);
            end
            send_next = 1'b1;
            step();
            send_next = 1'b0;
            code      = held;
        end
    endtask

    task automatic send_resp(input sb_msg_t code);
        rx_valid = 1'b1;
        rx_msg   = code;
        step();
        rx_valid = 1'b0;
        rx_msg   = '0;
    endtask

    task automatic apply_reset();
        tb_reset = 1'b1;
        repeat (2) step();
        tb_reset = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("%s finished with %0d errors", name, error_count - errs_before);
    endtask

    // Runs all four phases with a prompt answer to each request
    task automatic train_to_active(input string name, input int stall_max);
        sb_msg_t code;
        wait_state(name, SBINIT, REQ_WAIT);
        for (int i = 0; i < 4; i++) begin
            accept_msg(name, stall_max, code);
            check_msg(name, EXP_REQ[i], code);
            send_resp(EXP_REQ[i] | EXP_RESP_BIT);
            wait_state(name, NEXT_STATE[i], 10);
        end
        check_bit(name, 1'b1, link_active);
    endtask

    task automatic test_reset();
        int errs;
        errs = error_count;
        while (gen_reset !== 1'b0) begin
            step();
        end
        check_state("reset", RESET, ltsm_state);
        check_bit("reset", 1'b0, link_active);
        check_bit("reset", 1'b0, tx_valid);
        // No start request, so the dwell alone must not leave RESET
        repeat (2 * RESET_DWELL) begin
            step();
            check_state("reset", RESET, ltsm_state);
            check_bit("reset", 1'b0, tx_valid);
        end
        report_test("reset", errs);
    endtask

    task automatic test_full_training();
        int errs;
        errs     = error_count;
        start_lt = 1'b1;
        train_to_active("full_training", 0);
        repeat (2 * RETRY_CYCLES) begin
            step();
            check_bit("full_training", 1'b0, tx_valid);
        end
        report_test("full_training", errs);
    endtask

    task automatic test_retry();
        int      errs;
        sb_msg_t code;
        errs = error_count;
        apply_reset();
        wait_state("retry", SBINIT, REQ_WAIT);
        // First send and two resends go unanswered
        repeat (3) begin
            accept_msg("retry", 0, code);
            check_msg("retry", EXP_REQ[0], code);
            check_state("retry", SBINIT, ltsm_state);
        end
        send_resp(EXP_REQ[0] | EXP_RESP_BIT);
        wait_state("retry", MBINIT, 10);
        report_test("retry", errs);
    endtask

    task automatic test_wrong_resp();
        int      errs;
        sb_msg_t code;
        errs = error_count;
        accept_msg("wrong_resp", 0, code);
        check_msg("wrong_resp", EXP_REQ[1], code);
        // SBINIT answer arriving in MBINIT
        send_resp(EXP_REQ[0] | EXP_RESP_BIT);
        repeat (10) begin
            step();
            check_state("wrong_resp", MBINIT, ltsm_state);
        end
        send_resp(EXP_REQ[1] | EXP_RESP_BIT);
        wait_state("wrong_resp", MBTRAIN, 10);
        report_test("wrong_resp", errs);
    endtask

    task automatic test_timeout();
        int      errs;
        int      waited;
        int      sends;
        sb_msg_t code;
        errs   = error_count;
        waited = 0;
        sends  = 0;
        // Take every MBTRAIN request and never answer
        while (ltsm_state == MBTRAIN && waited < STATE_TIMEOUT + 20) begin
            send_next = tx_valid;
            if (tx_valid) begin
                check_msg("timeout", EXP_REQ[2], tx_msg);
                sends++;
            end
            step();
            waited++;
        end
        send_next = 1'b0;
        check_state("timeout", TRAINERROR, ltsm_state);
        if (sends < 2) begin
            note_failure("timeout", "the MBTRAIN request was not resent before the timeout");
        end
        accept_msg("timeout", 0, code);
        check_msg("timeout", EXP_ERR_MSG, code);
        check_state("timeout", RESET, ltsm_state);
        // With start_lt still high training restarts after the dwell
        accept_msg("timeout", 0, code);
        check_msg("timeout", EXP_REQ[0], code);
        check_state("timeout", SBINIT, ltsm_state);
        report_test("timeout", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = error_count;
        apply_reset();
        train_to_active("backpressure", 12);
        report_test("backpressure", errs);
    endtask

    initial begin
        tb_reset  = 1'b0;
        enable    = 1'b1;
        start_lt  = 1'b0;
        send_next = 1'b0;
        rx_valid  = 1'b0;
        rx_msg    = '0;
        test_reset();
        test_full_training();
        test_retry();
        test_wrong_resp();
        test_timeout();
        test_backpressure();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_100MHz);
        $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_100MHz,
    output logic reset
);

    initial begin
        clk_100MHz = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_100MHz = ~clk_100MHz;
        end
    end

    // Released just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_100MHz);
        #1 reset = 1'b0;
    end

endmodule

// File: files.f
rtl/ltsm_state_pkg.sv
rtl/sb_msg_pkg.sv
rtl/ltsm_sequencer.sv
rtl/phase_exchange.sv
rtl/sb_tx_select.sv
rtl/ltsm_top.sv
bench/tb_clock_gen.sv
bench/ltsm_tb.sv

// File: rtl/ltsm_sequencer.sv
`timescale 1ns/100ps

module ltsm_sequencer #(
    parameter int RESET_DWELL   = ltsm_state_pkg::DEF_RESET_DWELL,
    parameter int STATE_TIMEOUT = ltsm_state_pkg::DEF_STATE_TIMEOUT
) (
    input  logic                                clk_100MHz,
    input  logic                                reset,
    input  logic                                enable_i,
    input  logic                                start_lt_i,
    input  logic [ltsm_state_pkg::N_PHASES-1:0] phase_done_i,
    input  logic                                err_done_i,
    output logic [ltsm_state_pkg::N_PHASES-1:0] phase_en_o,
    output logic                                err_en_o,
    output ltsm_state_pkg::ltsm_state_t         state_o,
    output logic                                active_o
);
    import ltsm_state_pkg::*;

    localparam int DWELL_W = $clog2(RESET_DWELL + 1);
    localparam int TMO_W   = $clog2(STATE_TIMEOUT + 1);

    ltsm_state_t         state_q;
    ltsm_state_t         state_d;
    logic [DWELL_W-1:0]  dwell_cnt;
    logic                dwell_done;
    logic [TMO_W-1:0]    tmo_cnt;
    logic                tmo_hit;
    logic [N_PHASES-1:0] phase_en;
    logic                in_phase;

    // One-hot decode of the training phase states
    always_comb begin
        for (int i = 0; i < N_PHASES; i++) begin
            phase_en[i] = (state_q == phase_state[i]);
        end
    end

    assign in_phase   = |phase_en;
    assign dwell_done = (dwell_cnt == DWELL_W'(RESET_DWELL));
    assign tmo_hit    = (tmo_cnt == TMO_W'(STATE_TIMEOUT));

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RESET: begin
                if (enable_i && start_lt_i && dwell_done) begin
                    state_d = SBINIT;
                end
            end
            SBINIT: begin
                if (phase_done_i[0]) begin
                    state_d = MBINIT;
                end
            end
            MBINIT: begin
                if (phase_done_i[1]) begin
                    state_d = MBTRAIN;
                end
            end
            MBTRAIN: begin
                if (phase_done_i[2]) begin
                    state_d = LINKINIT;
                end
            end
            LINKINIT: begin
                if (phase_done_i[3]) begin
                    state_d = ACTIVE;
                end
            end
            TRAINERROR: begin
                if (err_done_i) begin
                    state_d = RESET;
                end
            end
            // Only reset leaves ACTIVE
            ACTIVE: begin
                state_d = ACTIVE;
            end
            default: begin
                state_d = RESET;
            end
        endcase

        // Timeout wins over a done in the same cycle
        if (in_phase && tmo_hit) begin
            state_d = TRAINERROR;
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_q <= RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Dwell restarts on every entry to RESET and holds once complete
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            dwell_cnt <= '0;
        end else if (state_q != RESET) begin
            dwell_cnt <= '0;
        end else if (!dwell_done) begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // State timeout, only runs inside the training phases
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            tmo_cnt <= '0;
        end else if (!in_phase || (state_d != state_q)) begin
            tmo_cnt <= '0;
        end else if (!tmo_hit) begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    assign phase_en_o = phase_en;
    assign err_en_o   = (state_q == TRAINERROR);
    assign active_o   = (state_q == ACTIVE);
    assign state_o    = state_q;

endmodule

// File: rtl/ltsm_state_pkg.sv
package ltsm_state_pkg;

    // Training states of the link state machine
    // Code 6 is unused since the L1/L2 state is not modelled
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        SBINIT     = 3'd1,
        MBINIT     = 3'd2,
        MBTRAIN    = 3'd3,
        LINKINIT   = 3'd4,
        ACTIVE     = 3'd5,
        TRAINERROR = 3'd7
    } ltsm_state_t;

    // Number of training phases between RESET and ACTIVE
    localparam int N_PHASES = 4;

    // Default timing in clk_100MHz cycles
    // Minimum stay in RESET before training may start
    localparam int DEF_RESET_DWELL = 100;

    // 8 ms per training state
    localparam int DEF_STATE_TIMEOUT = 800_000;

    // 1 us between resends of an unanswered request
    localparam int DEF_RETRY_CYCLES = 100;

    // Training state owned by each phase index
    localparam ltsm_state_t phase_state [N_PHASES] = '{
        SBINIT,
        MBINIT,
        MBTRAIN,
        LINKINIT
    };

endpackage

// File: rtl/ltsm_top.sv
`timescale 1ns/100ps

module ltsm_top #(
    parameter int RESET_DWELL   = ltsm_state_pkg::DEF_RESET_DWELL,
    parameter int STATE_TIMEOUT = ltsm_state_pkg::DEF_STATE_TIMEOUT,
    parameter int RETRY_CYCLES  = ltsm_state_pkg::DEF_RETRY_CYCLES
) (
    input  logic                        clk_100MHz,
    input  logic                        reset,
    input  logic                        enable_i,
    input  logic                        start_lt_i,
    input  logic                        sb_tx_send_next_i,
    input  logic                        sb_rx_valid_i,
    input  sb_msg_pkg::sb_msg_t         sb_rx_msg_i,
    output logic                        sb_tx_valid_o,
    output sb_msg_pkg::sb_msg_t         sb_tx_msg_o,
    output ltsm_state_pkg::ltsm_state_t ltsm_state_o,
    output logic                        ltsm_active_o
);
    import ltsm_state_pkg::*;
    import sb_msg_pkg::*;

    logic [N_PHASES-1:0] phase_en;
    logic [N_PHASES-1:0] phase_done;
    logic [N_PHASES-1:0] req_valid;
    sb_msg_t             req_msg [N_PHASES];
    logic                err_en;
    logic                err_done;

    ltsm_sequencer #(
        .RESET_DWELL  (RESET_DWELL),
        .STATE_TIMEOUT(STATE_TIMEOUT)
    ) sequencer_inst (
        .clk_100MHz  (clk_100MHz),
        .reset       (reset),
        .enable_i    (enable_i),
        .start_lt_i  (start_lt_i),
        .phase_done_i(phase_done),
        .err_done_i  (err_done),
        .phase_en_o  (phase_en),
        .err_en_o    (err_en),
        .state_o     (ltsm_state_o),
        .active_o    (ltsm_active_o)
    );

    // One request/response exchange per training phase
    for (genvar i = 0; i < N_PHASES; i++) begin : g_phase
        phase_exchange #(
            .REQ_CODE    (PHASE_REQ[i]),
            .RETRY_CYCLES(RETRY_CYCLES)
        ) phase_inst (
            .clk_100MHz    (clk_100MHz),
            .reset         (reset),
            .enable_i      (phase_en[i]),
            .sb_send_next_i(sb_tx_send_next_i),
            .sb_rx_valid_i (sb_rx_valid_i),
            .sb_rx_msg_i   (sb_rx_msg_i),
            .req_valid_o   (req_valid[i]),
            .req_msg_o     (req_msg[i]),
            .done_o        (phase_done[i])
        );
    end

    sb_tx_select select_inst (
        .clk_100MHz    (clk_100MHz),
        .reset         (reset),
        .req_valid_i   (req_valid),
        .req_msg_i     (req_msg),
        .err_en_i      (err_en),
        .sb_send_next_i(sb_tx_send_next_i),
        .sb_tx_valid_o (sb_tx_valid_o),
        .sb_tx_msg_o   (sb_tx_msg_o),
        .err_done_o    (err_done)
    );

endmodule

// File: rtl/phase_exchange.sv
`timescale 1ns/100ps

module phase_exchange #(
    parameter sb_msg_pkg::sb_msg_t REQ_CODE     = 8'h01,
    parameter int                  RETRY_CYCLES = ltsm_state_pkg::DEF_RETRY_CYCLES
) (
    input  logic                clk_100MHz,
    input  logic                reset,
    input  logic                enable_i,
    input  logic                sb_send_next_i,
    input  logic                sb_rx_valid_i,
    input  sb_msg_pkg::sb_msg_t sb_rx_msg_i,
    output logic                req_valid_o,
    output sb_msg_pkg::sb_msg_t req_msg_o,
    output logic                done_o
);
    import sb_msg_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SENDING,
        PH_WAITING,
        PH_DONE
    } phase_fsm_t;

    localparam int      RETRY_W   = $clog2(RETRY_CYCLES + 1);
    localparam sb_msg_t RESP_CODE = resp_code(REQ_CODE);

    phase_fsm_t         fsm_q;
    logic [RETRY_W-1:0] retry_cnt;
    logic               accepted_once;
    logic               rsp_seen;
    logic               rsp_hit;
    logic               retry_hit;
    logic               req_valid;

    // Matching response only counts once the request has gone out
    assign rsp_hit   = sb_rx_valid_i && (sb_rx_msg_i == RESP_CODE) && accepted_once;
    assign retry_hit = (retry_cnt == RETRY_W'(RETRY_CYCLES - 1));

    // Leaving the phase clears everything
    always_ff @(posedge clk_100MHz) begin
        if (reset || !enable_i) begin
            fsm_q         <= PH_IDLE;
            retry_cnt     <= '0;
            accepted_once <= 1'b0;
            rsp_seen      <= 1'b0;
        end else begin
            unique case (fsm_q)
                PH_IDLE: begin
                    fsm_q <= PH_SENDING;
                end
                PH_SENDING: begin
                    // A late answer during a resend is kept until the resend is taken
                    if (rsp_hit) begin
                        rsp_seen <= 1'b1;
                    end
                    if (sb_send_next_i) begin
                        accepted_once <= 1'b1;
                        retry_cnt     <= '0;
                        fsm_q         <= (rsp_hit || rsp_seen) ? PH_DONE : PH_WAITING;
                    end
                end
                PH_WAITING: begin
                    if (rsp_hit) begin
                        fsm_q <= PH_DONE;
                    end else if (retry_hit) begin
                        fsm_q <= PH_SENDING;
                    end else begin
                        retry_cnt <= retry_cnt + 1'b1;
                    end
                end
                PH_DONE: begin
                    fsm_q <= PH_DONE;
                end
                default: begin
                    fsm_q <= PH_IDLE;
                end
            endcase
        end
    end

    // Drop the request as soon as the phase is disabled
    assign req_valid   = (fsm_q == PH_SENDING) && enable_i;
    assign req_valid_o = req_valid;
    assign req_msg_o   = req_valid ? REQ_CODE : '0;
    assign done_o      = (fsm_q == PH_DONE);

endmodule

// File: rtl/sb_msg_pkg.sv
package sb_msg_pkg;

    // Width of a sideband message code
    localparam int SB_MSG_W = 8;

    // Parallel sideband message code
    typedef logic [SB_MSG_W-1:0] sb_msg_t;

    // Request code sent by each training phase
    // Same index order as the phase enables
    localparam sb_msg_t PHASE_REQ [ltsm_state_pkg::N_PHASES] = '{
        8'h01,
        8'h02,
        8'h03,
        8'h04
    };

    // Top bit marks a response
    localparam sb_msg_t RESP_FLAG = 8'h80;

    // Sent once on entry to TRAINERROR
    localparam sb_msg_t MSG_TRAINERROR_ENTRY = 8'h7F;

    // Response code the partner returns for a given request
    function automatic sb_msg_t resp_code(input sb_msg_t req);
        resp_code = req | RESP_FLAG;
    endfunction

endpackage

// File: rtl/sb_tx_select.sv
`timescale 1ns/100ps

module sb_tx_select (
    input  logic                                clk_100MHz,
    input  logic                                reset,
    input  logic [ltsm_state_pkg::N_PHASES-1:0] req_valid_i,
    input  sb_msg_pkg::sb_msg_t                 req_msg_i [ltsm_state_pkg::N_PHASES],
    input  logic                                err_en_i,
    input  logic                                sb_send_next_i,
    output logic                                sb_tx_valid_o,
    output sb_msg_pkg::sb_msg_t                 sb_tx_msg_o,
    output logic                                err_done_o
);
    import ltsm_state_pkg::*;
    import sb_msg_pkg::*;

    logic    phase_valid;
    sb_msg_t phase_msg;
    logic    err_pend;
    logic    err_sent;

    // AND-OR merge, only the enabled phase can be valid
    always_comb begin
        phase_valid = |req_valid_i;
        phase_msg   = '0;
        for (int i = 0; i < N_PHASES; i++) begin
            if (req_valid_i[i]) begin
                phase_msg = phase_msg | req_msg_i[i];
            end
        end
    end

    // One error-entry message per TRAINERROR visit
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            err_pend <= 1'b0;
            err_sent <= 1'b0;
        end else if (!err_en_i) begin
            err_pend <= 1'b0;
            err_sent <= 1'b0;
        end else if (err_pend) begin
            if (sb_send_next_i) begin
                err_pend <= 1'b0;
                err_sent <= 1'b1;
            end
        end else if (!err_sent) begin
            err_pend <= 1'b1;
        end
    end

    assign err_done_o    = err_pend && sb_send_next_i;
    assign sb_tx_valid_o = err_pend || phase_valid;
    assign sb_tx_msg_o   = err_pend ? MSG_TRAINERROR_ENTRY : phase_msg;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f files.f --top-module ltsm_tb -Mdir obj_dir
./obj_dir/Vltsm_tb > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
